//--- src/acq_defs.svh
`ifndef ACQ_DEFS_SVH
`define ACQ_DEFS_SVH

// ---------------------------------------------------------------------------
// bus and field widths
// ---------------------------------------------------------------------------
`define WB_ADR_W      3          // wishbone word address
`define WB_DAT_W      32         // wishbone data
`define PW_W          11         // pulse width field
`define PN_W          11         // pulse count field
`define GAP_W         16         // gap field, in clk_20 cycles
`define BTT_W         23         // data mover bytes to transfer
`define ADDR_W        32         // destination address

// ---------------------------------------------------------------------------
// fixed values
// ---------------------------------------------------------------------------
`define EOF_TAG       4'b1010    // tag marking end of frame
`define STARTUP_DELAY 64         // board runs 65534 here
`define LED_BIT       3          // heartbeat bit, toggles every 2^LED_BIT

// register word offsets
`define REG_CTRL      3'd0       // bit 0 starts a train
`define REG_WIDTH     3'd1
`define REG_NUM       3'd2
`define REG_GAP       3'd3
`define REG_BASE      3'd4       // write also rewinds the capture address
`define REG_BYTES     3'd5
`define REG_STATUS    3'd6       // read only

`endif

//--- src/acq_pkg.sv
`include "acq_defs.svh"

package acq_pkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;    // word offset
        logic [`WB_DAT_W-1:0] dat;    // write data
    } wb_req_t;

    // slave response
    typedef struct packed {
        logic                 ack;
        logic [`WB_DAT_W-1:0] dat;    // read data, valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic [`PW_W-1:0]     width;  // high cycles per pulse
        logic [`PN_W-1:0]     num;    // pulses per train
        logic [`GAP_W-1:0]    gap;    // low cycles between pulses
    } pulse_cfg_t;

    typedef struct packed {
        logic [`ADDR_W-1:0]   base;   // first destination address
        logic [`BTT_W-1:0]    bytes;  // bytes per capture
    } capture_cfg_t;

    // s2mm write command, field order matches the data mover layout
    typedef struct packed {
        logic [3:0]           tag;
        logic [`ADDR_W-1:0]   addr;
        logic                 eof;
        logic                 incr;   // incrementing burst
        logic [`BTT_W-1:0]    btt;
    } dm_cmd_t;

    typedef enum logic [`WB_ADR_W-1:0] {
        ADR_CTRL   = `REG_CTRL,
        ADR_WIDTH  = `REG_WIDTH,
        ADR_NUM    = `REG_NUM,
        ADR_GAP    = `REG_GAP,
        ADR_BASE   = `REG_BASE,
        ADR_BYTES  = `REG_BYTES,
        ADR_STATUS = `REG_STATUS
    } reg_addr_e;

endpackage

//--- src/acq_regs.sv
`include "acq_defs.svh"

module acq_regs (
    input  logic                  i_clk_20,
    input  logic                  i_rst_20,
    input  acq_pkg::wb_req_t      i_wb,
    output acq_pkg::wb_rsp_t      o_wb,
    output acq_pkg::pulse_cfg_t   o_pulse_cfg,
    output acq_pkg::capture_cfg_t o_cap_cfg,
    output logic                  o_start,
    output logic                  o_base_load,
    input  logic                  i_busy,
    input  logic                  i_cfg_done,
    input  logic [7:0]            i_cap_count,
    input  logic                  i_overrun
);
    import acq_pkg::*;

    logic                 req;          // request not yet acked
    logic                 wr_en;
    reg_addr_e            adr;
    logic                 ack_q;
    logic [`WB_DAT_W-1:0] rdat;
    logic [`WB_DAT_W-1:0] rdat_q;
    logic [`WB_DAT_W-1:0] status;
    pulse_cfg_t           pulse_cfg_q;
    capture_cfg_t         cap_cfg_q;

    assign req    = i_wb.cyc & i_wb.stb & ~ack_q;   // master drops stb after ack
    assign wr_en  = req & i_wb.we;
    assign adr    = reg_addr_e'(i_wb.adr);          // offset 7 falls to default
    assign status = {16'd0, i_cap_count, 5'd0, i_overrun, i_cfg_done, i_busy};

    // -----------------------------------------------------------------------
    // read mux, fields zero extended
    // -----------------------------------------------------------------------
    always_comb begin
        case (adr)
            ADR_WIDTH:  rdat = `WB_DAT_W'(pulse_cfg_q.width);
            ADR_NUM:    rdat = `WB_DAT_W'(pulse_cfg_q.num);
            ADR_GAP:    rdat = `WB_DAT_W'(pulse_cfg_q.gap);
            ADR_BASE:   rdat = cap_cfg_q.base;
            ADR_BYTES:  rdat = `WB_DAT_W'(cap_cfg_q.bytes);
            ADR_STATUS: rdat = status;
            default:    rdat = '0;                  // ctrl and unused offsets
        endcase
    end

    // -----------------------------------------------------------------------
    // ack, strobes and register writes, all on the edge that raises ack
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk_20) begin
        if (i_rst_20) begin
            ack_q       <= 1'b0;
            o_start     <= 1'b0;
            o_base_load <= 1'b0;
            pulse_cfg_q <= '0;                      // zero width means no train
            cap_cfg_q   <= '0;
        end else begin
            ack_q       <= req;                     // one cycle per request
            o_start     <= wr_en && (adr == ADR_CTRL) && i_wb.dat[0];  // self clearing
            o_base_load <= wr_en && (adr == ADR_BASE);
            if (wr_en) begin
                case (adr)
                    ADR_WIDTH: pulse_cfg_q.width <= i_wb.dat[`PW_W-1:0];
                    ADR_NUM:   pulse_cfg_q.num   <= i_wb.dat[`PN_W-1:0];
                    ADR_GAP:   pulse_cfg_q.gap   <= i_wb.dat[`GAP_W-1:0];
                    ADR_BASE:  cap_cfg_q.base    <= i_wb.dat[`ADDR_W-1:0];
                    ADR_BYTES: cap_cfg_q.bytes   <= i_wb.dat[`BTT_W-1:0];
                    default:   ;                    // ctrl handled by strobe
                endcase
            end
        end
    end

    // read data held until the next request
    always_ff @(posedge i_clk_20) begin
        if (req) begin
            rdat_q <= rdat;
        end
    end

    assign o_wb        = '{ack: ack_q, dat: rdat_q};
    assign o_pulse_cfg = pulse_cfg_q;
    assign o_cap_cfg   = cap_cfg_q;

    // master keeps stb up until it sees ack, slave must not ack twice
    ack_one_cycle: assert property (
        @(posedge i_clk_20) disable iff (i_rst_20)
        o_wb.ack |=> !o_wb.ack
    );

endmodule

//--- src/startup_seq.sv
`include "acq_defs.svh"

module startup_seq (
    input  logic i_clk_20,
    input  logic i_rst_20,
    input  logic i_cfg_done,
    output logic o_cfg_start,
    output logic o_cfg_done,
    output logic o_led
);
    localparam int DLY_W = $clog2(`STARTUP_DELAY + 2);  // room to park past fire

    logic [DLY_W-1:0]  dly_cnt;
    logic              done_q;       // config done seen
    logic [`LED_BIT:0] hb_cnt;       // heartbeat divider

    // -----------------------------------------------------------------------
    // power-up delay, one shot config start
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk_20) begin
        if (i_rst_20) begin
            dly_cnt     <= '0;
            o_cfg_start <= 1'b0;
        end else begin
            if (dly_cnt != DLY_W'(`STARTUP_DELAY + 1)) begin
                dly_cnt <= dly_cnt + 1'b1;  // saturates, so start fires once
            end
            o_cfg_start <= (dly_cnt == DLY_W'(`STARTUP_DELAY));
        end
    end

    // -----------------------------------------------------------------------
    // done latch and heartbeat
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk_20) begin
        if (i_rst_20) begin
            done_q <= 1'b0;
            hb_cnt <= '0;
        end else begin
            if (i_cfg_done) begin
                done_q <= 1'b1;             // sticky until reset
            end
            if (done_q) begin
                hb_cnt <= hb_cnt + 1'b1;    // free running once configured
            end
        end
    end

    assign o_cfg_done = done_q;
    assign o_led      = hb_cnt[`LED_BIT];   // low until done, counter idle at 0

    start_one_cycle: assert property (
        @(posedge i_clk_20) disable iff (i_rst_20)
        o_cfg_start |=> !o_cfg_start
    );

endmodule

//--- src/pulse_train.sv
`include "acq_defs.svh"

module pulse_train (
    input  logic                i_clk_20,
    input  logic                i_rst_20,
    input  acq_pkg::pulse_cfg_t i_cfg,
    input  logic                i_start,
    output logic                o_pulse,
    output logic                o_trig,
    output logic                o_busy
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_HIGH,
        S_GAP
    } state_e;

    state_e            state;
    logic [`GAP_W-1:0] cnt;          // down counter, shared by high and gap
    logic [`PN_W-1:0]  remain;       // pulses left incl. current
    logic [`PW_W-1:0]  width_q;      // settings held for the train
    logic [`GAP_W-1:0] gap_q;
    logic              trig_q;
    logic              go;

    // zero width or count gives nothing at all
    assign go = i_start && (i_cfg.width != '0) && (i_cfg.num != '0);

    // -----------------------------------------------------------------------
    // train FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk_20) begin
        if (i_rst_20) begin
            state  <= S_IDLE;
            cnt    <= '0;
            remain <= '0;
            trig_q <= 1'b0;
        end else begin
            trig_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state  <= S_HIGH;
                        cnt    <= `GAP_W'(i_cfg.width - 1'b1);
                        remain <= i_cfg.num;
                        trig_q <= 1'b1;             // capture with first edge
                    end
                end
                S_HIGH: begin
                    if (cnt == '0) begin
                        remain <= remain - 1'b1;
                        if (remain == `PN_W'(1)) begin
                            state <= S_GAP;         // one tail cycle, busy lags
                            cnt   <= '0;
                        end else if (gap_q == '0) begin
                            cnt <= `GAP_W'(width_q - 1'b1);  // back to back
                        end else begin
                            state <= S_GAP;
                            cnt   <= gap_q - 1'b1;
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_GAP: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (remain == '0) begin
                        state <= S_IDLE;            // train done
                    end else begin
                        state <= S_HIGH;
                        cnt   <= `GAP_W'(width_q - 1'b1);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // captured at start, later register writes wait for the next train
    always_ff @(posedge i_clk_20) begin
        if ((state == S_IDLE) && go) begin
            width_q <= i_cfg.width;
            gap_q   <= i_cfg.gap;
        end
    end

    assign o_pulse = (state == S_HIGH);
    assign o_trig  = trig_q;
    assign o_busy  = (state != S_IDLE);    // start while busy is ignored

    // low tail cycle keeps busy up after every pulse
    pulse_inside_busy: assert property (
        @(posedge i_clk_20) disable iff (i_rst_20)
        o_pulse |=> o_busy
    );

endmodule

//--- src/dm_cmd_gen.sv
`include "acq_defs.svh"

module dm_cmd_gen (
    input  logic                  i_clk_20,
    input  logic                  i_rst_20,
    input  acq_pkg::capture_cfg_t i_cfg,
    input  logic                  i_base_load,
    input  logic                  i_trig,
    output acq_pkg::dm_cmd_t      o_cmd,
    output logic                  o_cmd_valid,
    input  logic                  i_cmd_ready,
    output logic [7:0]            o_cap_count,
    output logic                  o_overrun
);
    import acq_pkg::*;

    dm_cmd_t            cmd_q;
    logic               valid_q;
    logic [`ADDR_W-1:0] next_addr;   // address for the next command
    logic [7:0]         cap_cnt;     // accepted commands, wraps
    logic               overrun_q;
    logic               accept;

    assign accept = valid_q & i_cmd_ready;

    // -----------------------------------------------------------------------
    // handshake, address walk, counters
    // -----------------------------------------------------------------------
    always_ff @(posedge i_clk_20) begin
        if (i_rst_20) begin
            valid_q   <= 1'b0;
            next_addr <= '0;
            cap_cnt   <= '0;
            overrun_q <= 1'b0;
        end else begin
            if (accept) begin
                valid_q <= 1'b0;
                cap_cnt <= cap_cnt + 1'b1;
            end
            if (i_trig) begin
                if (valid_q) begin
                    overrun_q <= 1'b1;          // one outstanding, trigger lost
                end else begin
                    valid_q <= 1'b1;
                end
            end
            if (i_base_load) begin
                next_addr <= i_cfg.base;        // rewind, overrun cleared too
                overrun_q <= 1'b0;
            end else if (accept) begin
                next_addr <= cmd_q.addr + `ADDR_W'(cmd_q.btt);
            end
        end
    end

    // command built on the trigger, frozen while waiting
    always_ff @(posedge i_clk_20) begin
        if (i_trig && !valid_q) begin
            cmd_q <= '{tag:  `EOF_TAG,
                       addr: next_addr,
                       eof:  1'b1,
                       incr: 1'b1,
                       btt:  i_cfg.bytes};
        end
    end

    assign o_cmd       = cmd_q;
    assign o_cmd_valid = valid_q;
    assign o_cap_count = cap_cnt;
    assign o_overrun   = overrun_q;

    // data mover may stall, payload must not move under it
    cmd_stable: assert property (
        @(posedge i_clk_20) disable iff (i_rst_20)
        o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd)
    );

endmodule

//--- src/acq_top.sv
module acq_top (
    input  logic              i_clk_20,
    input  logic              i_rst_20,
    input  acq_pkg::wb_req_t  i_wb,
    output acq_pkg::wb_rsp_t  o_wb,
    output logic              o_cfg_start,
    input  logic              i_cfg_done,
    output logic              o_led,
    output logic              o_pulse,
    output acq_pkg::dm_cmd_t  o_dm_cmd,
    output logic              o_dm_cmd_valid,
    input  logic              i_dm_cmd_ready
);
    import acq_pkg::*;

    pulse_cfg_t   pulse_cfg;     // regs to pulse train
    capture_cfg_t cap_cfg;       // regs to command gen
    logic         start;
    logic         base_load;
    logic         busy;
    logic         cfg_done;      // latched done, shown in status
    logic [7:0]   cap_count;
    logic         overrun;
    logic         trig;          // one per train

    // -----------------------------------------------------------------------
    // register block
    // -----------------------------------------------------------------------
    acq_regs u_regs (
        .i_clk_20    (i_clk_20),
        .i_rst_20    (i_rst_20),
        .i_wb        (i_wb),
        .o_wb        (o_wb),
        .o_pulse_cfg (pulse_cfg),
        .o_cap_cfg   (cap_cfg),
        .o_start     (start),
        .o_base_load (base_load),
        .i_busy      (busy),
        .i_cfg_done  (cfg_done),
        .i_cap_count (cap_count),
        .i_overrun   (overrun)
    );

    startup_seq u_startup (
        .i_clk_20    (i_clk_20),
        .i_rst_20    (i_rst_20),
        .i_cfg_done  (i_cfg_done),
        .o_cfg_start (o_cfg_start),
        .o_cfg_done  (cfg_done),
        .o_led       (o_led)
    );

    // -----------------------------------------------------------------------
    // pulse train and capture commands
    // -----------------------------------------------------------------------
    pulse_train u_pulse (
        .i_clk_20 (i_clk_20),
        .i_rst_20 (i_rst_20),
        .i_cfg    (pulse_cfg),
        .i_start  (start),
        .o_pulse  (o_pulse),
        .o_trig   (trig),
        .o_busy   (busy)
    );

    dm_cmd_gen u_cmd (
        .i_clk_20    (i_clk_20),
        .i_rst_20    (i_rst_20),
        .i_cfg       (cap_cfg),
        .i_base_load (base_load),
        .i_trig      (trig),
        .o_cmd       (o_dm_cmd),
        .o_cmd_valid (o_dm_cmd_valid),
        .i_cmd_ready (i_dm_cmd_ready),
        .o_cap_count (cap_count),
        .o_overrun   (overrun)
    );

endmodule

//--- verif/tb_acq_top.sv
`include "acq_defs.svh"

module tb_acq_top;
    import acq_pkg::*;

    localparam int MAX_W       = 5;     // pulse width drawn from 1..MAX_W
    localparam int MAX_N       = 4;
    localparam int MAX_G       = 4;
    localparam int N_TRAINS    = 7;     // 3 capture, 1 shape, 3 back-pressure
    localparam int CYCLE_LIMIT = `STARTUP_DELAY + MAX_N * (MAX_W + MAX_G) * N_TRAINS + 500;

    logic        clk_20;
    logic        rst_20;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        cfg_start;
    logic        cfg_done;
    logic        led;
    logic        pulse;
    dm_cmd_t     dm_cmd;
    logic        dm_valid;
    logic        dm_ready;
    int          err_count;
    int          chk_count;
    int          cycles;
    logic [31:0] lcg_state;

    initial begin
        clk_20 = 1'b0;
        forever #50 clk_20 = ~clk_20;           // 100 unit period
    end

    acq_top DUT (
        .i_clk_20       (clk_20),
        .i_rst_20       (rst_20),
        .i_wb           (wb_req),
        .o_wb           (wb_rsp),
        .o_cfg_start    (cfg_start),
        .i_cfg_done     (cfg_done),
        .o_led          (led),
        .o_pulse        (pulse),
        .o_dm_cmd       (dm_cmd),
        .o_dm_cmd_valid (dm_valid),
        .i_dm_cmd_ready (dm_ready)
    );

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int small_rand(input int hi);
        logic [31:0] r;
        r = lcg_next();
        return 1 + int'(r[23:16] % hi);         // upper bits, low ones cycle fast
    endfunction

    function automatic logic [31:0] field_mask(input int bits);
        return (bits >= 32) ? 32'hffff_ffff : ((32'd1 << bits) - 32'd1);
    endfunction

    // expected pin level t cycles after the first rise
    function automatic logic pulse_level(input int t, input int w, input int n, input int g);
        int p;
        p = w + g;
        if (t >= n * p - g) begin
            return 1'b0;                        // train over
        end
        return (t % p) < w;
    endfunction

    function automatic dm_cmd_t expected_cmd(input logic [31:0] addr,
                                             input logic [`BTT_W-1:0] btt);
        dm_cmd_t c;
        c.tag  = `EOF_TAG;
        c.addr = addr;
        c.eof  = 1'b1;
        c.incr = 1'b1;
        c.btt  = btt;
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic bit_equal(input string name, input logic got, input logic exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic word_equal(input string name, input logic [`WB_DAT_W-1:0] got,
                              input logic [`WB_DAT_W-1:0] exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic cmd_equal(input string name, input dm_cmd_t got, input dm_cmd_t exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // ------------------------------------------------------------------------
    // wishbone classic master, called on a falling edge
    // ------------------------------------------------------------------------
    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] dat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        n = 0;
        do begin
            @(negedge clk_20);
            n++;
        end while (!wb_rsp.ack && n < 8);
        wb_req = '0;                            // stb drops the cycle after ack
        if (!wb_rsp.ack) begin
            err_count++;
            $display("write to offset %0d was never acknowledged", adr);
        end
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] dat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        n = 0;
        do begin
            @(negedge clk_20);
            n++;
        end while (!wb_rsp.ack && n < 8);
        dat    = wb_rsp.dat;                    // valid with ack
        wb_req = '0;
        if (!wb_rsp.ack) begin
            err_count++;
            $display("read from offset %0d was never acknowledged", adr);
        end
    endtask

    task automatic wait_cmd_valid(output int n);
        n = 0;
        do begin
            @(negedge clk_20);
            n++;
        end while (!dm_valid && n < 40);
        if (!dm_valid) begin
            err_count++;
            $display("no data mover command appeared after the trigger");
        end
    endtask

    task automatic wait_train_idle();
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            wb_read(`REG_STATUS, st);
            n++;
        end while (st[0] && n < 100);
        if (st[0]) begin
            err_count++;
            $display("pulse train stayed busy");
        end
    endtask

    task automatic program_train(input int w, input int n, input int g);
        wb_write(`REG_WIDTH, w);
        wb_write(`REG_NUM, n);
        wb_write(`REG_GAP, g);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic startup_sequence_check();
        int          errs;
        int          k;
        int          n;
        logic [31:0] st;
        errs = err_count;
        bit_equal("o_cfg_start", cfg_start, 1'b0);  // still reset state here
        bit_equal("o_dm_cmd_valid", dm_valid, 1'b0);
        bit_equal("o_pulse", pulse, 1'b0);
        bit_equal("o_led", led, 1'b0);
        bit_equal("o_wb.ack", wb_rsp.ack, 1'b0);
        for (k = 1; k <= `STARTUP_DELAY + 4; k++) begin
            @(negedge clk_20);
            bit_equal("o_cfg_start", cfg_start, k == `STARTUP_DELAY + 1);
            bit_equal("o_led", led, 1'b0);      // no done yet
        end
        cfg_done = 1'b1;
        n = 0;
        while (!led && n < 32) begin
            @(negedge clk_20);
            n++;
        end
        bit_equal("o_led", led, 1'b1);          // heartbeat started
        n = 0;
        while (led && n < 40) begin
            @(negedge clk_20);
            n++;
        end
        word_equal("o_led high cycles", n, 1 << `LED_BIT);
        n = 0;
        while (!led && n < 40) begin
            @(negedge clk_20);
            n++;
        end
        word_equal("o_led low cycles", n, 1 << `LED_BIT);
        wb_read(`REG_STATUS, st);
        bit_equal("status.cfg_done", st[1], 1'b1);
        report_test("startup", errs);
    endtask

    task automatic register_readback();
        int                   errs;
        int                   i;
        logic [31:0]          val [5];
        logic [31:0]          got;
        logic [`WB_ADR_W-1:0] offs [5];
        int                   widths [5];
        errs   = err_count;
        offs   = '{`REG_WIDTH, `REG_NUM, `REG_GAP, `REG_BASE, `REG_BYTES};
        widths = '{`PW_W, `PN_W, `GAP_W, `ADDR_W, `BTT_W};
        for (i = 0; i < 5; i++) begin
            val[i] = lcg_next();                // full word, upper bits dropped
            wb_write(offs[i], val[i]);
        end
        for (i = 0; i < 5; i++) begin
            wb_read(offs[i], got);
            word_equal($sformatf("o_wb.dat offset %0d", offs[i]), got,
                       val[i] & field_mask(widths[i]));
        end
        wb_read(3'd7, got);                     // unused, still acks
        word_equal("o_wb.dat offset 7", got, 32'd0);
        report_test("registers", errs);
    endtask

    task automatic capture_commands();
        int          errs;
        int          i;
        int          lat;
        logic [31:0] base;
        logic [31:0] bytes;
        logic [31:0] st;
        errs     = err_count;
        dm_ready = 1'b1;
        program_train(small_rand(MAX_W), small_rand(MAX_N), small_rand(MAX_G));
        base  = lcg_next();
        bytes = lcg_next() & field_mask(`BTT_W);
        wb_write(`REG_BASE, base);
        wb_write(`REG_BYTES, bytes);
        for (i = 0; i < 3; i++) begin
            wb_write(`REG_CTRL, 32'd1);
            wait_cmd_valid(lat);
            word_equal("cycles from ack to o_dm_cmd_valid", lat, 2);
            cmd_equal("o_dm_cmd", dm_cmd,
                      expected_cmd(base + i * bytes, bytes[`BTT_W-1:0]));
            @(negedge clk_20);
            bit_equal("o_dm_cmd_valid", dm_valid, 1'b0);  // taken, ready high
            wait_train_idle();
        end
        wb_read(`REG_STATUS, st);
        word_equal("status.cap_count", {24'd0, st[15:8]}, 32'd3);
        bit_equal("status.overrun", st[2], 1'b0);
        report_test("capture commands", errs);
    endtask

    task automatic pulse_shape();
        int          errs;
        int          w;
        int          n;
        int          g;
        int          len;
        int          t;
        logic [31:0] st;
        errs = err_count;
        w    = small_rand(MAX_W);
        n    = small_rand(MAX_N);
        g    = small_rand(MAX_G);
        len  = n * (w + g) + 4;                 // whole train plus the busy tail
        program_train(w, n, g);
        wb_write(`REG_CTRL, 32'd1);
        fork
            begin
                for (t = 0; t < len; t++) begin
                    @(negedge clk_20);
                    bit_equal("o_pulse", pulse, pulse_level(t, w, n, g));
                end
            end
            begin
                wb_read(`REG_STATUS, st);       // mid train
                bit_equal("status.busy", st[0], 1'b1);
            end
        join
        wb_read(`REG_STATUS, st);
        bit_equal("status.busy", st[0], 1'b0);
        report_test($sformatf("pulse train w=%0d n=%0d g=%0d", w, n, g), errs);
    endtask

    task automatic idle_with_zero_count();
        int          errs;
        int          t;
        logic [31:0] st;
        errs = err_count;
        wb_write(`REG_NUM, 32'd0);
        wb_write(`REG_CTRL, 32'd1);
        for (t = 0; t < 10; t++) begin
            @(negedge clk_20);
            bit_equal("o_pulse", pulse, 1'b0);
            bit_equal("o_dm_cmd_valid", dm_valid, 1'b0);  // no trigger either
        end
        wb_read(`REG_STATUS, st);
        bit_equal("status.busy", st[0], 1'b0);
        report_test("zero count", errs);
    endtask

    task automatic backpressure_overrun();
        int          errs;
        int          lat;
        logic [31:0] base;
        logic [31:0] bytes;
        logic [31:0] st;
        dm_cmd_t     held;
        errs     = err_count;
        dm_ready = 1'b0;                        // data mover stalls
        program_train(small_rand(MAX_W), small_rand(MAX_N), small_rand(MAX_G));
        base  = lcg_next();
        bytes = lcg_next() & field_mask(`BTT_W);
        wb_write(`REG_BASE, base);
        wb_write(`REG_BYTES, bytes);
        wb_write(`REG_CTRL, 32'd1);
        wait_cmd_valid(lat);
        held = dm_cmd;
        cmd_equal("o_dm_cmd", held, expected_cmd(base, bytes[`BTT_W-1:0]));
        wait_train_idle();
        wb_write(`REG_CTRL, 32'd1);             // trigger lands on a waiting command
        wait_train_idle();
        wb_read(`REG_STATUS, st);
        bit_equal("status.overrun", st[2], 1'b1);
        bit_equal("o_dm_cmd_valid", dm_valid, 1'b1);
        cmd_equal("o_dm_cmd", dm_cmd, held);    // unchanged under stall
        dm_ready = 1'b1;
        @(negedge clk_20);
        bit_equal("o_dm_cmd_valid", dm_valid, 1'b0);
        base = lcg_next();
        wb_write(`REG_BASE, base);              // rewind and clear overrun
        wb_read(`REG_STATUS, st);
        bit_equal("status.overrun", st[2], 1'b0);
        wb_write(`REG_CTRL, 32'd1);
        wait_cmd_valid(lat);
        cmd_equal("o_dm_cmd", dm_cmd, expected_cmd(base, bytes[`BTT_W-1:0]));
        wait_train_idle();
        report_test("back-pressure and overrun", errs);
    endtask

    // ------------------------------------------------------------------------
    // sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rst_20    = 1'b1;
        wb_req    = '0;
        cfg_done  = 1'b0;
        dm_ready  = 1'b0;
        err_count = 0;
        chk_count = 0;
        lcg_state = 32'hd73d_6af4;
        repeat (10) @(negedge clk_20);          // 10 rising edges in reset
        rst_20 = 1'b0;
        startup_sequence_check();
        register_readback();
        capture_commands();
        pulse_shape();
        idle_with_zero_count();
        backpressure_overrun();
        $display("%0d checks, %0d errors", chk_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_20);
            cycles++;
        end
        $display("timeout after %0d cycles", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/acq_pkg.sv
src/acq_regs.sv
src/startup_seq.sv
src/pulse_train.sv
src/dm_cmd_gen.sv
src/acq_top.sv
verif/tb_acq_top.sv

//--- Bender.yml
package:
  name: acq_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/acq_pkg.sv
      - src/acq_regs.sv
      - src/startup_seq.sv
      - src/pulse_train.sv
      - src/dm_cmd_gen.sv
      - src/acq_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_acq_top.sv
